// File: files.f
source/tea_pkg.sv
source/scan_decoder.sv
source/operand_loader.sv
source/tea_sequencer.sv
source/tea_datapath.sv
source/result_display.sv
source/tea_machine.sv
verification/tb_clock_gen.sv
verification/tea_machine_asserts.sv
verification/tea_machine_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the TEA machine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tea_machine_tb \
	-f files.f \
	-o tea_machine_sim

./obj_dir/tea_machine_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: source/operand_loader.sv
module operand_loader (
	input  logic                 clk,
	input  logic                 resetFlag,
	input  tea_pkg::key_event_t  key_event,
	input  tea_pkg::nibble_t     key_digit,
	input  logic                 load_phase,
	output tea_pkg::word_t       v0_init,
	output tea_pkg::word_t       v1_init,
	output tea_pkg::word_t       key0,
	output tea_pkg::word_t       key1,
	output tea_pkg::word_t       key2,
	output tea_pkg::word_t       key3
);
	import tea_pkg::*;

	word_t slots [NUM_SLOTS];
	slot_t slot_ptr;
	logic  load_phase_q;
	logic  ptr_in_range;

	assign ptr_in_range = slot_ptr < slot_t'(NUM_SLOTS);

	always_ff @(posedge clk) begin
		if (resetFlag || key_event == KEY_CLEAR) begin
			slots <= '{default: '0};
			slot_ptr <= '0;
			load_phase_q <= 1'b1;
		end else begin
			load_phase_q <= load_phase;
			if (load_phase && !load_phase_q) begin
				slot_ptr <= '0;  // new loading round
			end else if (load_phase) begin
				case (key_event)
					KEY_DIGIT: begin
						if (ptr_in_range)
							slots[slot_ptr] <= word_t'(key_digit);  // digit is the whole word
					end
					KEY_NEXT: begin
						if (ptr_in_range)
							slot_ptr <= slot_ptr + 3'd1;
					end
					default: ;
				endcase
			end
		end
	end

	// slot order v0 v1 k0 k1 k2 k3
	assign v0_init = slots[0];
	assign v1_init = slots[1];
	assign key0    = slots[2];
	assign key1    = slots[3];
	assign key2    = slots[4];
	assign key3    = slots[5];

endmodule

// File: source/result_display.sv
module result_display (
	input  logic                 clk,
	input  logic                 resetFlag,
	input  tea_pkg::key_event_t  key_event,
	input  logic                 show_result,
	input  tea_pkg::word_t       v0_work,
	input  tea_pkg::word_t       v1_work,
	output tea_pkg::segments_t   hex0,
	output tea_pkg::segments_t   hex1,
	output tea_pkg::segments_t   hex2,
	output tea_pkg::segments_t   hex3,
	output tea_pkg::segments_t   hex4,
	output tea_pkg::segments_t   hex5,
	output logic [7:0]           leds
);
	import tea_pkg::*;

	word_t shown;  // v1 low half above v0 low half

	function automatic segments_t hex_segments(input nibble_t digit);
		case (digit)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110;  // F
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (resetFlag || key_event == KEY_CLEAR)
			shown <= '0;
		else if (show_result)
			shown <= {v1_work[15:0], v0_work[15:0]};
	end

	assign hex0 = hex_segments(shown[3:0]);
	assign hex1 = hex_segments(shown[7:4]);
	assign hex2 = hex_segments(shown[11:8]);
	assign hex3 = hex_segments(shown[19:16]);
	assign hex4 = hex_segments(shown[23:20]);
	assign hex5 = hex_segments(shown[27:24]);

	// top nibble of each half has no digit
	assign leds = {shown[31:28], shown[15:12]};

endmodule

// File: source/scan_decoder.sv
module scan_decoder (
	input  logic                 clk,
	input  logic                 resetFlag,
	input  tea_pkg::scan_code_t  scan_code,
	input  logic                 scan_valid,
	output tea_pkg::key_event_t  key_event,
	output tea_pkg::nibble_t     key_digit
);
	import tea_pkg::*;

	logic       break_pending;
	key_event_t code_event;
	nibble_t    code_digit;

	// classify one make code
	always_comb begin
		code_event = KEY_DIGIT;
		code_digit = 4'd0;
		case (scan_code)
			SC_DIGIT_0: code_digit = 4'd0;
			SC_DIGIT_1: code_digit = 4'd1;
			SC_DIGIT_2: code_digit = 4'd2;
			SC_DIGIT_3: code_digit = 4'd3;
			SC_DIGIT_4: code_digit = 4'd4;
			SC_DIGIT_5: code_digit = 4'd5;
			SC_DIGIT_6: code_digit = 4'd6;
			SC_DIGIT_7: code_digit = 4'd7;
			SC_DIGIT_8: code_digit = 4'd8;
			SC_DIGIT_9: code_digit = 4'd9;
			SC_SPACE:   code_event = KEY_NEXT;
			SC_ENTER:   code_event = KEY_ENTER;
			SC_E:       code_event = KEY_ENCRYPT;
			SC_D:       code_event = KEY_DECRYPT;
			SC_ESC:     code_event = KEY_CLEAR;
			default:    code_event = KEY_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetFlag) begin
			break_pending <= 1'b0;
			key_event <= KEY_NONE;
		end else begin
			key_event <= KEY_NONE;
			if (scan_valid) begin
				if (break_pending) begin
					break_pending <= 1'b0;  // byte of a released key is dropped
				end else if (scan_code == SC_BREAK) begin
					break_pending <= 1'b1;
				end else begin
					key_event <= code_event;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (scan_valid)
			key_digit <= code_digit;
	end

endmodule

// File: source/tea_datapath.sv
module tea_datapath (
	input  logic                 clk,
	input  logic                 resetFlag,
	input  tea_pkg::key_event_t  key_event,
	input  tea_pkg::tea_step_t   step,
	input  logic                 decrypt_mode,
	input  tea_pkg::word_t       v0_init,
	input  tea_pkg::word_t       v1_init,
	input  tea_pkg::word_t       key0,
	input  tea_pkg::word_t       key1,
	input  tea_pkg::word_t       key2,
	input  tea_pkg::word_t       key3,
	output tea_pkg::word_t       v0_work,
	output tea_pkg::word_t       v1_work
);
	import tea_pkg::*;

	word_t sum;
	word_t term_a;  // (x << 4) + ka
	word_t term_b;  // x + sum
	word_t term_c;  // (x >> 5) + kb

	logic  mix_v1;
	logic  update_v0;
	word_t mix_src;
	word_t mix_ka;
	word_t mix_kb;
	word_t mix_x;
	word_t update_dst;
	word_t update_val;

	// encrypt mixes v1 first and decrypt mixes v0 first
	always_comb begin
		mix_v1 = (step == STEP_MIX_A) != decrypt_mode;
		mix_src = mix_v1 ? v1_work : v0_work;
		mix_ka = mix_v1 ? key0 : key2;
		mix_kb = mix_v1 ? key1 : key3;

		// and the other word takes the result
		update_v0 = (step == STEP_UPDATE_A) != decrypt_mode;
		update_dst = update_v0 ? v0_work : v1_work;
		mix_x = term_a ^ term_b ^ term_c;
		update_val = decrypt_mode ? update_dst - mix_x : update_dst + mix_x;
	end

	always_ff @(posedge clk) begin
		if (resetFlag || key_event == KEY_CLEAR) begin
			v0_work <= '0;
			v1_work <= '0;
			sum <= '0;
			term_a <= '0;
			term_b <= '0;
			term_c <= '0;
		end else begin
			case (step)
				STEP_START: begin
					if (decrypt_mode) begin
						sum <= TEA_DEC_SUM_INIT;  // v0/v1 still hold the ciphertext
					end else begin
						v0_work <= v0_init;
						v1_work <= v1_init;
						sum <= '0;
					end
				end
				STEP_SUM: begin
					sum <= decrypt_mode ? sum - TEA_DELTA : sum + TEA_DELTA;
				end
				STEP_MIX_A, STEP_MIX_B: begin
					term_a <= (mix_src << TEA_SHIFT_LEFT) + mix_ka;
					term_b <= mix_src + sum;
					term_c <= (mix_src >> TEA_SHIFT_RIGHT) + mix_kb;
				end
				STEP_UPDATE_A, STEP_UPDATE_B: begin
					if (update_v0)
						v0_work <= update_val;
					else
						v1_work <= update_val;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: source/tea_machine.sv
module tea_machine (
	input  logic                 clk,
	input  logic                 resetFlag,
	input  tea_pkg::scan_code_t  scan_code,
	input  logic                 scan_valid,
	output tea_pkg::segments_t   hex0,
	output tea_pkg::segments_t   hex1,
	output tea_pkg::segments_t   hex2,
	output tea_pkg::segments_t   hex3,
	output tea_pkg::segments_t   hex4,
	output tea_pkg::segments_t   hex5,
	output logic [7:0]           leds
);
	import tea_pkg::*;

	key_event_t key_event;  // also carries the Esc clear strobe
	nibble_t    key_digit;
	logic       load_phase;
	tea_step_t  step;
	logic       decrypt_mode;
	logic       show_result;
	word_t      v0_init, v1_init;
	word_t      key0, key1, key2, key3;
	word_t      v0_work, v1_work;

	scan_decoder u_scan (
		.clk(clk), .resetFlag(resetFlag),
		.scan_code(scan_code), .scan_valid(scan_valid),
		.key_event(key_event), .key_digit(key_digit)
	);

	operand_loader u_loader (
		.clk(clk), .resetFlag(resetFlag),
		.key_event(key_event), .key_digit(key_digit), .load_phase(load_phase),
		.v0_init(v0_init), .v1_init(v1_init),
		.key0(key0), .key1(key1), .key2(key2), .key3(key3)
	);

	tea_sequencer u_seq (
		.clk(clk), .resetFlag(resetFlag), .key_event(key_event),
		.load_phase(load_phase), .step(step),
		.decrypt_mode(decrypt_mode), .show_result(show_result)
	);

	tea_datapath u_dp (
		.clk(clk), .resetFlag(resetFlag), .key_event(key_event),
		.step(step), .decrypt_mode(decrypt_mode),
		.v0_init(v0_init), .v1_init(v1_init),
		.key0(key0), .key1(key1), .key2(key2), .key3(key3),
		.v0_work(v0_work), .v1_work(v1_work)
	);

	result_display u_disp (
		.clk(clk), .resetFlag(resetFlag), .key_event(key_event),
		.show_result(show_result), .v0_work(v0_work), .v1_work(v1_work),
		.hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5),
		.leds(leds)
	);

endmodule

// File: source/tea_pkg.sv
package tea_pkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0]  scan_code_t;
	typedef logic [2:0]  slot_t;      // 0..6 where 6 is past the last slot
	typedef logic [6:0]  segments_t;  // active low in g..a order
	typedef logic [3:0]  nibble_t;

	typedef enum logic [2:0] {
		STEP_IDLE,
		STEP_START,
		STEP_SUM,
		STEP_MIX_A,
		STEP_UPDATE_A,
		STEP_MIX_B,
		STEP_UPDATE_B
	} tea_step_t;

	typedef enum logic [2:0] {
		KEY_NONE,
		KEY_DIGIT,
		KEY_NEXT,
		KEY_ENTER,
		KEY_ENCRYPT,
		KEY_DECRYPT,
		KEY_CLEAR
	} key_event_t;

	// set-2 make codes
	localparam scan_code_t SC_DIGIT_0 = 8'h45;
	localparam scan_code_t SC_DIGIT_1 = 8'h16;
	localparam scan_code_t SC_DIGIT_2 = 8'h1E;
	localparam scan_code_t SC_DIGIT_3 = 8'h26;
	localparam scan_code_t SC_DIGIT_4 = 8'h25;
	localparam scan_code_t SC_DIGIT_5 = 8'h2E;
	localparam scan_code_t SC_DIGIT_6 = 8'h36;
	localparam scan_code_t SC_DIGIT_7 = 8'h3D;
	localparam scan_code_t SC_DIGIT_8 = 8'h3E;
	localparam scan_code_t SC_DIGIT_9 = 8'h46;
	localparam scan_code_t SC_SPACE   = 8'h29;
	localparam scan_code_t SC_ENTER   = 8'h5A;
	localparam scan_code_t SC_E       = 8'h24;
	localparam scan_code_t SC_D       = 8'h23;
	localparam scan_code_t SC_ESC     = 8'h76;
	localparam scan_code_t SC_BREAK   = 8'hF0;  // release prefix

	localparam word_t TEA_DELTA        = 32'h9E3779B9;
	localparam word_t TEA_DEC_SUM_INIT = 32'hC6EF3720;  // delta * 32
	localparam int    TEA_ROUNDS       = 32;
	localparam int    TEA_SHIFT_LEFT   = 4;
	localparam int    TEA_SHIFT_RIGHT  = 5;

	localparam int NUM_SLOTS = 6;

endpackage

// File: source/tea_sequencer.sv
module tea_sequencer (
	input  logic                 clk,
	input  logic                 resetFlag,
	input  tea_pkg::key_event_t  key_event,
	output logic                 load_phase,
	output tea_pkg::tea_step_t   step,
	output logic                 decrypt_mode,
	output logic                 show_result
);
	import tea_pkg::*;

	typedef enum logic [2:0] {
		PH_LOAD,
		PH_WAIT_ENCRYPT,
		PH_ENCRYPTING,
		PH_WAIT_DECRYPT,
		PH_DECRYPTING
	} phase_t;

	phase_t    phase;
	logic [5:0] round;
	tea_step_t first_step;
	tea_step_t last_step;
	tea_step_t next_step;
	logic      pass_done;

	// decryption runs the same cycle but enters at MIX_A
	assign first_step = decrypt_mode ? STEP_MIX_A : STEP_SUM;
	assign last_step  = decrypt_mode ? STEP_SUM : STEP_UPDATE_B;
	assign pass_done  = (step == last_step) && (round == 6'(TEA_ROUNDS));

	always_comb begin
		case (step)
			STEP_START:    next_step = first_step;
			STEP_SUM:      next_step = STEP_MIX_A;
			STEP_MIX_A:    next_step = STEP_UPDATE_A;
			STEP_UPDATE_A: next_step = STEP_MIX_B;
			STEP_MIX_B:    next_step = STEP_UPDATE_B;
			STEP_UPDATE_B: next_step = STEP_SUM;
			default:       next_step = STEP_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetFlag || key_event == KEY_CLEAR) begin
			phase <= PH_LOAD;
			step <= STEP_IDLE;
			round <= '0;
			decrypt_mode <= 1'b0;
			show_result <= 1'b0;
		end else begin
			show_result <= 1'b0;
			case (phase)
				PH_LOAD: begin
					if (key_event == KEY_ENTER)
						phase <= PH_WAIT_ENCRYPT;
				end
				PH_WAIT_ENCRYPT: begin
					if (key_event == KEY_ENCRYPT) begin
						phase <= PH_ENCRYPTING;
						step <= STEP_START;
						round <= '0;
						decrypt_mode <= 1'b0;
					end
				end
				PH_WAIT_DECRYPT: begin
					if (key_event == KEY_DECRYPT) begin
						phase <= PH_DECRYPTING;
						step <= STEP_START;
						round <= '0;
						decrypt_mode <= 1'b1;
					end
				end
				default: begin  // keys ignored while a pass runs
					step <= next_step;
					if (step == first_step)
						round <= round + 6'd1;
					if (pass_done) begin
						step <= STEP_IDLE;
						show_result <= 1'b1;
						phase <= decrypt_mode ? PH_LOAD : PH_WAIT_DECRYPT;
					end
				end
			endcase
		end
	end

	assign load_phase = (phase == PH_LOAD);

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;  // free running

endmodule

// File: verification/tea_machine_asserts.sv
module tea_machine_asserts (
	input logic                clk,
	input logic                resetFlag,
	input logic [2:0]          phase,
	input tea_pkg::tea_step_t  step,
	input logic                load_phase,
	input logic                show_result
);
	import tea_pkg::*;

	// phase codes as encoded in tea_sequencer
	localparam logic [2:0] PH_ENCRYPTING = 3'd2;
	localparam logic [2:0] PH_DECRYPTING = 3'd4;

	logic in_pass;

	assign in_pass = (phase == PH_ENCRYPTING) || (phase == PH_DECRYPTING);

	show_single_cycle: assert property (@(posedge clk) disable iff (resetFlag)
		show_result |=> !show_result)
		else $error("show_result stayed high for two cycles");

	idle_outside_pass: assert property (@(posedge clk) disable iff (resetFlag)
		!in_pass |-> step == STEP_IDLE)
		else $error("step not idle while no pass is running");

	no_step_while_loading: assert property (@(posedge clk) disable iff (resetFlag)
		!(load_phase && step != STEP_IDLE))
		else $error("load_phase high together with an active step");

endmodule

bind tea_sequencer tea_machine_asserts u_asserts (
	.clk(clk),
	.resetFlag(resetFlag),
	.phase(phase),
	.step(step),
	.load_phase(load_phase),
	.show_result(show_result)
);

// File: verification/tea_machine_tb.sv
module tea_machine_tb;
	import tea_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int PASS_CYCLES  = 200;  // a pass takes 164 cycles
	localparam int BYTE_CYCLES  = 40;
	localparam int NUM_ROWS     = 4;
	localparam int unsigned RANDOM_SEED = 32'hb7a0e745;

	typedef struct packed {
		logic [23:0] digits;         // slot 0 in the low nibble
		logic        early_e;        // E pressed before Enter
		logic        has_release;
		logic [2:0]  release_slot;
		nibble_t     release_digit;  // sent after a break prefix
		logic [15:0] plain_v0;
		logic [15:0] plain_v1;
	} stim_row_t;

	logic       clk;
	logic       resetFlag;
	scan_code_t scan_code;
	logic       scan_valid;
	segments_t  hex0, hex1, hex2, hex3, hex4, hex5;
	logic [7:0] leds;

	stim_row_t   rows [NUM_ROWS];
	logic        table_ready = 1'b0;
	logic [15:0] shown_v0;
	logic [15:0] shown_v1;

	tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

	tea_machine u_dut (
		.clk(clk), .resetFlag(resetFlag),
		.scan_code(scan_code), .scan_valid(scan_valid),
		.hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5),
		.leds(leds)
	);

	// reference TEA encryption giving {v1, v0}
	function automatic logic [63:0] tea_encrypt(input word_t p0, input word_t p1,
			input word_t k0, input word_t k1, input word_t k2, input word_t k3);
		word_t y;
		word_t z;
		word_t total;
		y = p0;
		z = p1;
		total = '0;
		for (int r = 0; r < TEA_ROUNDS; r++) begin
			total = total + TEA_DELTA;
			y = y + (((z << 4) + k0) ^ (z + total) ^ ((z >> 5) + k1));
			z = z + (((y << 4) + k2) ^ (y + total) ^ ((y >> 5) + k3));
		end
		return {z, y};
	endfunction

	function automatic segments_t expected_segments(input nibble_t n);
		logic [6:0] lit;  // gfedcba, 1 = segment on
		case (n)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h67;  // no bottom bar
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	function automatic scan_code_t digit_code(input nibble_t d);
		case (d)
			4'd0: return SC_DIGIT_0;
			4'd1: return SC_DIGIT_1;
			4'd2: return SC_DIGIT_2;
			4'd3: return SC_DIGIT_3;
			4'd4: return SC_DIGIT_4;
			4'd5: return SC_DIGIT_5;
			4'd6: return SC_DIGIT_6;
			4'd7: return SC_DIGIT_7;
			4'd8: return SC_DIGIT_8;
			default: return SC_DIGIT_9;
		endcase
	endfunction

	task automatic fill_table();
		rows[0] = {24'h654321, 1'b0, 1'b0, 3'd0, 4'd0, 16'h0001, 16'h0002};
		rows[1] = {24'h528079, 1'b1, 1'b0, 3'd0, 4'd0, 16'h0009, 16'h0007};
		rows[2] = {24'h319904, 1'b0, 1'b1, 3'd0, 4'd8, 16'h0004, 16'h0000};
		rows[3] = {24'h261738, 1'b0, 1'b0, 3'd0, 4'd0, 16'h0008, 16'h0003};
	endtask

	task automatic check_segments(input string name, input segments_t got,
			input segments_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at time %0t: %s = %b, expected %b", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "seven-segment output mismatch");
		end
	endtask

	task automatic check_leds(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at time %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "led output mismatch");
		end
	endtask

	// v1 low half above v0 low half
	task automatic check_display(input logic [15:0] lo_v0, input logic [15:0] lo_v1);
		logic [31:0] word;
		word = {lo_v1, lo_v0};
		check_segments("hex0", hex0, expected_segments(word[3:0]));
		check_segments("hex1", hex1, expected_segments(word[7:4]));
		check_segments("hex2", hex2, expected_segments(word[11:8]));
		check_segments("hex3", hex3, expected_segments(word[19:16]));
		check_segments("hex4", hex4, expected_segments(word[23:20]));
		check_segments("hex5", hex5, expected_segments(word[27:24]));
		check_leds("leds", leds, {word[31:28], word[15:12]});
		shown_v0 = lo_v0;
		shown_v1 = lo_v1;
	endtask

	task automatic send_byte(input scan_code_t code);
		int unsigned gap;
		@(negedge clk);
		scan_code = code;
		scan_valid = 1'b1;
		@(negedge clk);
		scan_valid = 1'b0;
		scan_code = '0;
		gap = 1 + ($urandom % 4);
		repeat (gap) @(negedge clk);
	endtask

	task automatic wait_pass();
		repeat (PASS_CYCLES) @(negedge clk);
	endtask

	task automatic run_row(input stim_row_t row);
		logic [63:0] cipher;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			send_byte(digit_code(row.digits[4*s +: 4]));
			if (row.has_release && int'(row.release_slot) == s) begin
				send_byte(SC_BREAK);
				send_byte(digit_code(row.release_digit));
			end
			send_byte(SC_SPACE);
		end
		if (row.early_e) begin
			send_byte(SC_E);  // still loading, must be ignored
			wait_pass();
			check_display(shown_v0, shown_v1);
		end
		send_byte(SC_ENTER);
		send_byte(SC_E);
		wait_pass();
		cipher = tea_encrypt(word_t'(row.digits[3:0]), word_t'(row.digits[7:4]),
			word_t'(row.digits[11:8]), word_t'(row.digits[15:12]),
			word_t'(row.digits[19:16]), word_t'(row.digits[23:20]));
		check_display(cipher[15:0], cipher[47:32]);
		send_byte(SC_D);
		wait_pass();
		check_display(row.plain_v0, row.plain_v1);
	endtask

	initial begin
		logic [63:0] cipher;
		resetFlag = 1'b1;
		scan_code = '0;
		scan_valid = 1'b0;
		shown_v0 = '0;
		shown_v1 = '0;
		void'($urandom(RANDOM_SEED));
		fill_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		resetFlag = 1'b0;
		@(negedge clk);
		check_display(16'h0000, 16'h0000);
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(rows[i]);
		// Esc wipes the display and every operand
		send_byte(SC_ESC);
		repeat (4) @(negedge clk);
		check_display(16'h0000, 16'h0000);
		send_byte(SC_ENTER);
		send_byte(SC_E);
		wait_pass();
		cipher = tea_encrypt('0, '0, '0, '0, '0, '0);
		check_display(cipher[15:0], cipher[47:32]);
		send_byte(SC_D);
		wait_pass();
		check_display(16'h0000, 16'h0000);
		$display("TB PASSED");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		int passes;
		int bytes;
		int timeout_cycles;
		wait (table_ready);
		passes = 2;  // zero-operand pass and its decrypt
		bytes = 4;
		for (int i = 0; i < NUM_ROWS; i++) begin
			passes = passes + 2 + int'(rows[i].early_e);
			bytes = bytes + 15 + int'(rows[i].early_e) + 2 * int'(rows[i].has_release);
		end
		timeout_cycles = passes * PASS_CYCLES + bytes * BYTE_CYCLES + RESET_CYCLES;
		#(timeout_cycles * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule
